//--- rtl/baser_block_decoder.sv
// 64b/66b half-block decoder that finds frame boundaries and framing errors and aligns frame words
module baser_block_decoder (
    input  logic                              clk,
    input  logic                              reset_crc,
    input  logic [baser_rx_pkg::data_w-1:0]   rx_data,
    input  logic [1:0]                        rx_hdr,
    input  logic                              rx_hdr_valid,
    output logic [baser_rx_pkg::data_w-1:0]   crc_data,
    output logic [baser_rx_pkg::data_w-1:0]   out_data,
    output logic                              frame_start,
    output logic                              term_present,
    output logic                              term_first,
    output logic [1:0]                        term_lane,
    output logic                              framing_error
);

    logic [baser_rx_pkg::data_w-1:0] rx_data_reg;
    logic [1:0]                      rx_hdr_reg;
    logic                            rx_hdr_valid_reg;

    logic [baser_rx_pkg::data_w-1:0] data_d0;
    logic [baser_rx_pkg::data_w-1:0] data_d1;
    logic [baser_rx_pkg::data_w-1:0] data_d2;

    logic start_alt;
    logic start_d0;
    logic start_d1;
    logic start_d2;

    // terminate found in the upper half, reported with the following word
    logic       term_alt_present;
    logic       term_alt_first;
    logic [1:0] term_alt_lane;

    logic frame_open;

    function automatic logic [3:0] type_nib(input baser_rx_pkg::block_type_t bt);
        return bt[7:4];
    endfunction

    // clear the bytes from the terminate lane upwards
    function automatic logic [31:0] zero_from(input logic [31:0] word, input logic [1:0] lane);
        return word & ~(32'hffffffff << (8 * lane));
    endfunction

    assign crc_data    = data_d0;
    assign out_data    = data_d2;
    assign frame_start = start_d2;

    always_ff @(posedge clk) begin
        rx_data_reg      <= rx_data;
        rx_hdr_reg       <= rx_hdr;
        rx_hdr_valid_reg <= rx_hdr_valid;

        data_d0 <= rx_data_reg;
        data_d1 <= data_d0;
        data_d2 <= data_d1;

        start_alt <= 1'b0;
        start_d0  <= start_alt;
        start_d1  <= start_d0;
        start_d2  <= start_d1;

        term_alt_present <= 1'b0;
        term_alt_first   <= 1'b0;
        term_alt_lane    <= 2'd0;
        term_present     <= term_alt_present;
        term_first       <= term_alt_first;
        term_lane        <= term_alt_lane;

        framing_error <= 1'b0;

        if (rx_hdr_valid_reg) begin
            if (rx_hdr_reg == baser_rx_pkg::sync_data) begin
                framing_error <= !frame_open;
            end else if (rx_hdr_reg == baser_rx_pkg::sync_ctrl) begin
                // for terminate types the low two nibble bits give the lane within the half
                case (rx_data_reg[7:4])
                    type_nib(baser_rx_pkg::start_0): begin
                        start_d0      <= 1'b1;
                        framing_error <= frame_open;
                        frame_open    <= 1'b1;
                    end
                    type_nib(baser_rx_pkg::start_4), type_nib(baser_rx_pkg::os_start): begin
                        start_alt     <= 1'b1;
                        framing_error <= frame_open;
                        frame_open    <= 1'b1;
                    end
                    type_nib(baser_rx_pkg::term_0), type_nib(baser_rx_pkg::term_1),
                    type_nib(baser_rx_pkg::term_2), type_nib(baser_rx_pkg::term_3): begin
                        data_d0       <= zero_from(rx_data_reg >> 8, rx_data_reg[5:4]);
                        term_present  <= 1'b1;
                        term_first    <= rx_data_reg[5:4] == 2'd0;
                        term_lane     <= rx_data_reg[5:4];
                        framing_error <= !frame_open;
                        frame_open    <= 1'b0;
                    end
                    type_nib(baser_rx_pkg::term_4), type_nib(baser_rx_pkg::term_5),
                    type_nib(baser_rx_pkg::term_6), type_nib(baser_rx_pkg::term_7): begin
                        // borrow byte 4 from the half-block still at the input
                        data_d0          <= {rx_data[7:0], rx_data_reg[31:8]};
                        term_alt_present <= 1'b1;
                        term_alt_first   <= rx_data_reg[5:4] == 2'd0;
                        term_alt_lane    <= rx_data_reg[5:4];
                        framing_error    <= !frame_open;
                        frame_open       <= 1'b0;
                    end
                    type_nib(baser_rx_pkg::ctrl), type_nib(baser_rx_pkg::os_4),
                    type_nib(baser_rx_pkg::os_04), type_nib(baser_rx_pkg::os_0): begin
                        framing_error <= frame_open;
                        frame_open    <= 1'b0;
                    end
                    default: begin
                        // unknown block type closes the frame as well
                        framing_error <= frame_open;
                        frame_open    <= 1'b0;
                    end
                endcase
            end else begin
                framing_error <= frame_open;
                frame_open    <= 1'b0;
            end
        end else if (term_alt_present) begin
            data_d0 <= zero_from(rx_data_reg >> 8, term_alt_lane);
        end

        if (reset_crc) begin
            rx_hdr_valid_reg <= 1'b0;
            start_alt        <= 1'b0;
            start_d0         <= 1'b0;
            start_d1         <= 1'b0;
            start_d2         <= 1'b0;
            term_alt_present <= 1'b0;
            term_alt_first   <= 1'b0;
            term_present     <= 1'b0;
            term_first       <= 1'b0;
            framing_error    <= 1'b0;
            frame_open       <= 1'b0;
        end
    end

endmodule

//--- rtl/baser_rx.sv
// 10GBASE-R frame receiver from 32-bit half-blocks to an Ethernet byte stream with status pulses
module baser_rx (
    input  logic                              clk,
    input  logic                              reset_crc,
    input  logic [baser_rx_pkg::data_w-1:0]   rx_data,
    input  logic [1:0]                        rx_hdr,
    input  logic                              rx_hdr_valid,
    output logic [baser_rx_pkg::data_w-1:0]   rx_tdata,
    output logic [baser_rx_pkg::keep_w-1:0]   rx_tkeep,
    output logic                              rx_tvalid,
    output logic                              rx_tlast,
    output logic                              rx_tuser,
    output logic                              stat_pkt_good,
    output logic                              stat_pkt_bad,
    output logic                              stat_err_bad_fcs,
    output logic                              stat_err_framing,
    output logic                              stat_err_preamble,
    output logic [15:0]                       stat_pkt_len
);

    logic [baser_rx_pkg::data_w-1:0] crc_data;
    logic [baser_rx_pkg::data_w-1:0] out_data;
    logic                            frame_start;
    logic                            term_present;
    logic                            term_first;
    logic [1:0]                      term_lane;
    logic                            framing_error;
    logic [baser_rx_pkg::keep_w-1:0] crc_match;
    logic                            crc_clear;

    baser_block_decoder u_decoder (
        .clk           (clk),
        .reset_crc     (reset_crc),
        .rx_data       (rx_data),
        .rx_hdr        (rx_hdr),
        .rx_hdr_valid  (rx_hdr_valid),
        .crc_data      (crc_data),
        .out_data      (out_data),
        .frame_start   (frame_start),
        .term_present  (term_present),
        .term_first    (term_first),
        .term_lane     (term_lane),
        .framing_error (framing_error)
    );

    eth_fcs_check u_fcs (
        .clk       (clk),
        .reset_crc (reset_crc),
        .crc_data  (crc_data),
        .crc_clear (crc_clear),
        .crc_match (crc_match)
    );

    baser_rx_frame_fsm u_fsm (
        .clk               (clk),
        .reset_crc         (reset_crc),
        .out_data          (out_data),
        .frame_start       (frame_start),
        .term_present      (term_present),
        .term_first        (term_first),
        .term_lane         (term_lane),
        .framing_error     (framing_error),
        .crc_match         (crc_match),
        .crc_clear         (crc_clear),
        .rx_tdata          (rx_tdata),
        .rx_tkeep          (rx_tkeep),
        .rx_tvalid         (rx_tvalid),
        .rx_tlast          (rx_tlast),
        .rx_tuser          (rx_tuser),
        .stat_pkt_good     (stat_pkt_good),
        .stat_pkt_bad      (stat_pkt_bad),
        .stat_err_bad_fcs  (stat_err_bad_fcs),
        .stat_err_framing  (stat_err_framing),
        .stat_err_preamble (stat_err_preamble),
        .stat_pkt_len      (stat_pkt_len)
    );

endmodule

//--- rtl/baser_rx_frame_fsm.sv
// Receive frame FSM that strips the preamble, drives the output stream and reports frame status
module baser_rx_frame_fsm (
    input  logic                              clk,
    input  logic                              reset_crc,
    input  logic [baser_rx_pkg::data_w-1:0]   out_data,
    input  logic                              frame_start,
    input  logic                              term_present,
    input  logic                              term_first,
    input  logic [1:0]                        term_lane,
    input  logic                              framing_error,
    input  logic [baser_rx_pkg::keep_w-1:0]   crc_match,
    output logic                              crc_clear,
    output logic [baser_rx_pkg::data_w-1:0]   rx_tdata,
    output logic [baser_rx_pkg::keep_w-1:0]   rx_tkeep,
    output logic                              rx_tvalid,
    output logic                              rx_tlast,
    output logic                              rx_tuser,
    output logic                              stat_pkt_good,
    output logic                              stat_pkt_bad,
    output logic                              stat_err_bad_fcs,
    output logic                              stat_err_framing,
    output logic                              stat_err_preamble,
    output logic [15:0]                       stat_pkt_len
);

    baser_rx_pkg::rx_state_t state;

    // terminate seen on lanes 1..3, one more full word before the last beat
    logic        term_wait;
    logic [1:0]  lane_reg;
    logic        crc_ok;
    logic        pre_ok;
    logic [15:0] len_reg;
    logic [2:0]  len_add;
    logic [15:0] len_sum;

    assign len_add = (state == baser_rx_pkg::st_last && lane_reg != 2'd0) ?
                     {1'b0, lane_reg} : 3'd4;
    assign len_sum = (&len_reg[15:2]) ? 16'hffff : len_reg + 16'(len_add);

    always_ff @(posedge clk) begin
        rx_tdata          <= out_data;
        rx_tkeep          <= '1;
        rx_tvalid         <= 1'b0;
        rx_tlast          <= 1'b0;
        rx_tuser          <= 1'b0;
        stat_pkt_good     <= 1'b0;
        stat_pkt_bad      <= 1'b0;
        stat_err_bad_fcs  <= 1'b0;
        stat_err_framing  <= 1'b0;
        stat_err_preamble <= 1'b0;
        stat_pkt_len      <= 16'd0;
        crc_clear         <= 1'b0;

        case (state)
            baser_rx_pkg::st_idle: begin
                crc_clear <= 1'b1;
                term_wait <= 1'b0;
                len_reg   <= 16'd0;
                pre_ok    <= out_data[31:8] == {3{baser_rx_pkg::eth_pre}};
                if (framing_error) begin
                    stat_err_framing <= 1'b1;
                end else if (frame_start) begin
                    crc_clear <= 1'b0;
                    state     <= baser_rx_pkg::st_preamble;
                end
            end
            baser_rx_pkg::st_preamble: begin
                // SFD word is checked and dropped
                len_reg <= 16'd0;
                pre_ok  <= pre_ok && out_data == {baser_rx_pkg::eth_sfd,
                                                  {3{baser_rx_pkg::eth_pre}}};
                if (framing_error) begin
                    stat_err_framing <= 1'b1;
                    crc_clear        <= 1'b1;
                    state            <= baser_rx_pkg::st_idle;
                end else begin
                    state <= baser_rx_pkg::st_payload;
                end
            end
            baser_rx_pkg::st_payload: begin
                rx_tvalid <= 1'b1;
                len_reg   <= len_sum;
                if (term_wait) begin
                    crc_ok <= crc_match[lane_reg - 2'd1];
                    state  <= baser_rx_pkg::st_last;
                end else if (framing_error) begin
                    rx_tlast          <= 1'b1;
                    rx_tuser          <= 1'b1;
                    stat_pkt_bad      <= 1'b1;
                    stat_err_framing  <= 1'b1;
                    stat_err_preamble <= !pre_ok;
                    stat_pkt_len      <= len_sum;
                    crc_clear         <= 1'b1;
                    state             <= baser_rx_pkg::st_idle;
                end else if (term_first) begin
                    // the word after this one is full and holds the end of the FCS
                    lane_reg <= 2'd0;
                    crc_ok   <= crc_match[3];
                    state    <= baser_rx_pkg::st_last;
                end else if (term_present) begin
                    lane_reg  <= term_lane;
                    term_wait <= 1'b1;
                end
            end
            baser_rx_pkg::st_last: begin
                rx_tvalid <= 1'b1;
                rx_tlast  <= 1'b1;
                if (lane_reg != 2'd0) begin
                    rx_tkeep <= ~(4'b1111 << lane_reg);
                end
                rx_tuser          <= !crc_ok;
                stat_pkt_good     <= crc_ok;
                stat_pkt_bad      <= !crc_ok;
                stat_err_bad_fcs  <= !crc_ok;
                stat_err_preamble <= !pre_ok;
                stat_pkt_len      <= len_sum;
                crc_clear         <= 1'b1;
                state             <= baser_rx_pkg::st_idle;
            end
        endcase

        if (reset_crc) begin
            state             <= baser_rx_pkg::st_idle;
            term_wait         <= 1'b0;
            crc_clear         <= 1'b1;
            rx_tvalid         <= 1'b0;
            stat_pkt_good     <= 1'b0;
            stat_pkt_bad      <= 1'b0;
            stat_err_bad_fcs  <= 1'b0;
            stat_err_framing  <= 1'b0;
            stat_err_preamble <= 1'b0;
        end
    end

endmodule

//--- rtl/baser_rx_pkg.sv
// 10GBASE-R receive definitions for widths, sync headers, block types, frame states and CRC-32
package baser_rx_pkg;

    localparam int data_w = 32;
    localparam int keep_w = data_w / 8;

    localparam logic [1:0] sync_data = 2'b10;
    localparam logic [1:0] sync_ctrl = 2'b01;

    // upper nibble is unique per type, terminate types are 8h..fh
    typedef enum logic [7:0] {
        ctrl     = 8'h1e,
        os_4     = 8'h2d,
        start_4  = 8'h33,
        os_start = 8'h66,
        os_04    = 8'h55,
        start_0  = 8'h78,
        os_0     = 8'h4b,
        term_0   = 8'h87,
        term_1   = 8'h99,
        term_2   = 8'haa,
        term_3   = 8'hb4,
        term_4   = 8'hcc,
        term_5   = 8'hd2,
        term_6   = 8'he1,
        term_7   = 8'hff
    } block_type_t;

    typedef enum logic [1:0] {
        st_idle,
        st_preamble,
        st_payload,
        st_last
    } rx_state_t;

    localparam logic [7:0] eth_pre = 8'h55;
    localparam logic [7:0] eth_sfd = 8'hd5;

    // reflected polynomial, state preset to all ones with no final inversion
    localparam logic [31:0] crc_poly = 32'hedb88320;

    // state after a good FCS whose last byte sits on lane 0..3, upper lanes zero padded
    localparam logic [31:0] crc_residue_lane [keep_w] = '{
        32'h62932081,
        32'h4e3d5e5c,
        32'h39dd08e2,
        32'hdebb20e3
    };

endpackage

//--- rtl/eth_fcs_check.sv
// Ethernet FCS checker running CRC-32 over 32-bit words and matching the per-lane residues
module eth_fcs_check (
    input  logic                              clk,
    input  logic                              reset_crc,
    input  logic [baser_rx_pkg::data_w-1:0]   crc_data,
    input  logic                              crc_clear,
    output logic [baser_rx_pkg::keep_w-1:0]   crc_match
);

    logic [31:0] crc_state;
    logic [31:0] crc_start;
    logic [31:0] crc_next;

    // one bit per step, lsb of byte 0 first
    function automatic logic [31:0] crc_step(input logic [31:0] state, input logic [31:0] data);
        logic [31:0] s;
        s = state;
        for (int i = 0; i < 32; i++) begin
            if (s[0] ^ data[i]) begin
                s = (s >> 1) ^ baser_rx_pkg::crc_poly;
            end else begin
                s = s >> 1;
            end
        end
        return s;
    endfunction

    // crc_clear restarts the CRC with the word at crc_data as the first one
    assign crc_start = crc_clear ? 32'hffffffff : crc_state;
    assign crc_next  = crc_step(crc_start, crc_data);

    always_ff @(posedge clk) begin
        crc_state <= crc_next;

        for (int i = 0; i < baser_rx_pkg::keep_w; i++) begin
            crc_match[i] <= crc_next == baser_rx_pkg::crc_residue_lane[i];
        end

        if (reset_crc) begin
            crc_state <= 32'hffffffff;
            crc_match <= '0;
        end
    end

endmodule

//--- sim.f
rtl/baser_rx_pkg.sv
rtl/baser_block_decoder.sv
rtl/eth_fcs_check.sv
rtl/baser_rx_frame_fsm.sv
rtl/baser_rx.sv
test/baser_rx_tb.sv

//--- test/baser_rx_stimulus.txt
# F: start lane, frame length with FCS, corrupted byte index (0 none), bad preamble, cut after data blocks (0 none)
# S: good, bad, bad FCS, framing, preamble, length; I: idle blocks; D: data block while idle
I 4
F 0 64 0 0 0
S 1 0 0 0 0 64
F 0 65 0 0 0
S 1 0 0 0 0 65
F 0 66 0 0 0
S 1 0 0 0 0 66
F 0 67 0 0 0
S 1 0 0 0 0 67
F 0 68 0 0 0
S 1 0 0 0 0 68
F 0 69 0 0 0
S 1 0 0 0 0 69
F 0 70 0 0 0
S 1 0 0 0 0 70
F 0 71 0 0 0
S 1 0 0 0 0 71
F 4 64 0 0 0
S 1 0 0 0 0 64
F 4 65 0 0 0
S 1 0 0 0 0 65
F 4 66 0 0 0
S 1 0 0 0 0 66
F 4 67 0 0 0
S 1 0 0 0 0 67
F 4 68 0 0 0
S 1 0 0 0 0 68
F 4 69 0 0 0
S 1 0 0 0 0 69
F 4 70 0 0 0
S 1 0 0 0 0 70
F 4 71 0 0 0
S 1 0 0 0 0 71
F 4 66 20 0 0
S 0 1 1 0 0 66
F 0 65 0 1 0
S 1 0 0 0 1 65
F 4 70 0 1 0
S 1 0 0 0 1 70
F 0 64 0 0 3
S 0 1 0 1 0 20
I 2
D
S 0 0 0 1 0 0
I 2
F 0 72 0 0 0
S 1 0 0 0 0 72

//--- test/baser_rx_tb.sv
// testbench for the 10GBASE-R frame receiver driven from a stimulus file with ordered output checks
module baser_rx_tb;

    timeunit 1ns;
    timeprecision 1ps;

    logic        clk;
    logic        reset_crc;
    logic [31:0] rx_data;
    logic [1:0]  rx_hdr;
    logic        rx_hdr_valid;
    logic [31:0] rx_tdata;
    logic [3:0]  rx_tkeep;
    logic        rx_tvalid;
    logic        rx_tlast;
    logic        rx_tuser;
    logic        stat_pkt_good;
    logic        stat_pkt_bad;
    logic        stat_err_bad_fcs;
    logic        stat_err_framing;
    logic        stat_err_preamble;
    logic [15:0] stat_pkt_len;

    // half-blocks to drive as {hdr_valid, hdr, data}
    logic [34:0] in_half[$];
    // expected beats {data, keep, last, user} and status {good, bad, fcs, framing, pre, len}
    logic [37:0] exp_beat[$];
    logic [20:0] exp_stat[$];

    int frame_num = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    baser_rx uut (
        .clk               (clk),
        .reset_crc         (reset_crc),
        .rx_data           (rx_data),
        .rx_hdr            (rx_hdr),
        .rx_hdr_valid      (rx_hdr_valid),
        .rx_tdata          (rx_tdata),
        .rx_tkeep          (rx_tkeep),
        .rx_tvalid         (rx_tvalid),
        .rx_tlast          (rx_tlast),
        .rx_tuser          (rx_tuser),
        .stat_pkt_good     (stat_pkt_good),
        .stat_pkt_bad      (stat_pkt_bad),
        .stat_err_bad_fcs  (stat_err_bad_fcs),
        .stat_err_framing  (stat_err_framing),
        .stat_err_preamble (stat_err_preamble),
        .stat_pkt_len      (stat_pkt_len)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    // reflected CRC-32 taken one byte at a time
    function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] b);
        logic [31:0] r;
        r = c ^ {24'd0, b};
        for (int k = 0; k < 8; k++) begin
            r = r[0] ? ((r >> 1) ^ 32'hedb88320) : (r >> 1);
        end
        return r;
    endfunction

    function automatic logic [7:0] frame_byte(input int num, input int idx);
        return 8'((idx * 29) ^ (idx >> 3) ^ (num << 4));
    endfunction

    function automatic logic [7:0] term_type(input int lanes);
        case (lanes)
            0: return 8'h87;
            1: return 8'h99;
            2: return 8'haa;
            3: return 8'hb4;
            4: return 8'hcc;
            5: return 8'hd2;
            6: return 8'he1;
            default: return 8'hff;
        endcase
    endfunction

    // byte 0 of the block sits in bits 7:0
    task automatic add_block(input logic [1:0] hdr, input logic [63:0] blk);
        in_half.push_back({1'b1, hdr, blk[31:0]});
        in_half.push_back({1'b0, hdr, blk[63:32]});
    endtask

    task automatic build_frame(input int start, input int len, input int flip,
                               input int badpre, input int cut);
        logic [7:0]  f[$];
        logic [7:0]  q[$];
        logic [31:0] crc;
        logic [63:0] blk;
        logic [31:0] w;
        logic [3:0]  keep;
        int          blocks;
        int          nwords;
        crc = 32'hffffffff;
        for (int i = 0; i < len - 4; i++) begin
            f.push_back(frame_byte(frame_num, i));
            crc = crc_byte(crc, f[i]);
        end
        crc = ~crc;
        for (int i = 0; i < 4; i++) begin
            f.push_back(crc[8*i +: 8]);
        end
        if (flip != 0) begin
            f[flip] = f[flip] ^ 8'h01;
        end
        if (start == 0) begin
            blk = 64'hd5555555_55555578;
            if (badpre != 0) begin
                blk[39:32] = 8'h54;
            end
            add_block(2'b01, blk);
            q = f;
        end else begin
            add_block(2'b01, 64'h55555500_00000033);
            q = {(badpre != 0) ? 8'h54 : 8'h55, 8'h55, 8'h55, 8'hd5};
            foreach (f[i]) q.push_back(f[i]);
        end
        blocks = 0;
        while (q.size() >= 8 && (cut == 0 || blocks < cut)) begin
            for (int j = 0; j < 8; j++) begin
                blk[8*j +: 8] = q.pop_front();
            end
            add_block(2'b10, blk);
            blocks++;
        end
        if (cut != 0) begin
            // an idle block inside the frame drops the word just before it
            add_block(2'b01, 64'h1e);
            nwords = (cut * 8 - ((start == 0) ? 0 : 4)) / 4;
            for (int i = 0; i < nwords - 1; i++) begin
                w = {f[4*i+3], f[4*i+2], f[4*i+1], f[4*i]};
                exp_beat.push_back({w, 4'hf, i == nwords - 2, i == nwords - 2});
            end
        end else begin
            blk = 64'd0;
            blk[7:0] = term_type(q.size());
            foreach (q[j]) blk[8*(j+1) +: 8] = q[j];
            add_block(2'b01, blk);
            for (int i = 0; i < len; i += 4) begin
                w = 32'd0;
                keep = 4'd0;
                for (int k = 0; k < 4; k++) begin
                    if (i + k < len) begin
                        w[8*k +: 8] = f[i+k];
                        keep[k] = 1'b1;
                    end
                end
                exp_beat.push_back({w, keep, i + 4 >= len, flip != 0 && i + 4 >= len});
            end
        end
        add_block(2'b01, 64'h1e);
        add_block(2'b01, 64'h1e);
        frame_num++;
    endtask

    task automatic load_stimulus();
        int    fd;
        int    n;
        string line;
        byte   kind;
        int    a, b, c, d, e, g;
        fd = $fopen("test/baser_rx_stimulus.txt", "r");
        if (fd == 0) begin
            report_failure("could not open the stimulus file");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%c %d %d %d %d %d %d", kind, a, b, c, d, e, g);
                    case (kind)
                        "F": build_frame(a, b, c, d, e);
                        "S": exp_stat.push_back({a[0], b[0], c[0], d[0], e[0], g[15:0]});
                        "I": repeat (a) add_block(2'b01, 64'h1e);
                        "D": begin
                            add_block(2'b10, 64'h0123456789abcdef);
                            add_block(2'b01, 64'h1e);
                        end
                        default: report_failure("unknown record in the stimulus file");
                    endcase
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic send_half(input logic [34:0] h);
        @(posedge clk);
        #1;
        rx_hdr_valid = h[34];
        rx_hdr       = h[33:32];
        rx_data      = h[31:0];
    endtask

    task automatic check_beat();
        logic [37:0] e;
        logic [31:0] mask;
        assert (exp_beat.size() != 0) else begin
            report_failure($sformatf("output beat at %0t with no beat expected", $time));
        end
        if (exp_beat.size() != 0) begin
            e = exp_beat.pop_front();
            for (int k = 0; k < 4; k++) begin
                mask[8*k +: 8] = e[k+2] ? 8'hff : 8'h00;
            end
            assert ((rx_tdata & mask) == (e[37:6] & mask) && rx_tkeep == e[5:2]
                    && rx_tlast == e[1] && rx_tuser == e[0]) else begin
                report_failure($sformatf(
                    "FAILED at %0t: beat %h keep %h last %b user %b, expected %h %h %b %b",
                    $time, rx_tdata, rx_tkeep, rx_tlast, rx_tuser,
                    e[37:6], e[5:2], e[1], e[0]));
            end
        end
    endtask

    task automatic check_status();
        logic [20:0] e;
        logic [20:0] got;
        got = {stat_pkt_good, stat_pkt_bad, stat_err_bad_fcs, stat_err_framing,
               stat_err_preamble, stat_pkt_len};
        assert (exp_stat.size() != 0) else begin
            report_failure($sformatf("status pulse at %0t with no status expected", $time));
        end
        if (exp_stat.size() != 0) begin
            e = exp_stat.pop_front();
            assert (got == e) else begin
                report_failure($sformatf(
                    "FAILED at %0t: status %b len %0d, expected %b len %0d",
                    $time, got[20:16], got[15:0], e[20:16], e[15:0]));
            end
        end
    endtask

    // outputs are registered on the rising edge and read on the falling one
    always @(negedge clk) begin
        if (!reset_crc) begin
            // a frame ends in the same cycle as its good or bad pulse
            assert ((rx_tvalid && rx_tlast) == (stat_pkt_good || stat_pkt_bad)) else begin
                report_failure($sformatf(
                    "FAILED at %0t: last beat %b with good or bad status %b",
                    $time, rx_tvalid && rx_tlast, stat_pkt_good || stat_pkt_bad));
            end
            if (rx_tvalid) begin
                check_beat();
            end
            if (stat_pkt_good || stat_pkt_bad || stat_err_bad_fcs || stat_err_framing
                || stat_err_preamble) begin
                check_status();
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            report_failure("timeout reached before all inputs were sent");
        end
    end

    initial begin
        reset_crc    = 1'b1;
        rx_data      = 32'd0;
        rx_hdr       = 2'b01;
        rx_hdr_valid = 1'b0;
        load_stimulus();
        cycle_limit = in_half.size() + 64 + 10;
        repeat (5) begin
            send_half({1'b1, 2'b01, 32'h1e});
            send_half({1'b0, 2'b01, 32'h0});
        end
        reset_crc = 1'b0;
        foreach (in_half[i]) send_half(in_half[i]);
        // drain the pipeline with idles
        repeat (8) begin
            send_half({1'b1, 2'b01, 32'h1e});
            send_half({1'b0, 2'b01, 32'h0});
        end
        if (exp_beat.size() != 0 || exp_stat.size() != 0) begin
            report_failure("outputs missing, expected beats or status records were never seen");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule
